//--- src.f
+incdir+test
design/cpuPkg.sv
design/pipeReg.sv
design/fetchUnit.sv
design/controlDecoder.sv
design/regFile.sv
design/executeUnit.sv
design/hazardUnit.sv
design/cpuTop.sv
test/cpuTb.sv

//--- test/programTable.svh
`ifndef programTableSvh
`define programTableSvh

// ==================================================
// Fixed program, word index = pc / 4
// ==================================================
localparam int fixedLen = 27;

localparam cpuPkg::wordT fixedProg [fixedLen] = '{
  32'h123450B7, // 0  lui  x1, 0x12345
  32'h67808113, // 1  addi x2, x1, 0x678
  32'h00500193, // 2  addi x3, x0, 5
  32'h00310233, // 3  add  x4, x2, x3
  32'h403202B3, // 4  sub  x5, x4, x3
  32'h0022C333, // 5  xor  x6, x5, x2
  32'h003263B3, // 6  or   x7, x4, x3
  32'h00327433, // 7  and  x8, x4, x3
  32'hFFF00493, // 8  addi x9, x0, -1
  32'h0034A533, // 9  slt  x10, x9, x3
  32'h0091A5B3, // 10 slt  x11, x3, x9
  32'h04000613, // 11 addi x12, x0, 0x40
  32'h00262423, // 12 sw   x2, 8(x12)
  32'h00862683, // 13 lw   x13, 8(x12)
  32'h00368733, // 14 add  x14, x13, x3
  32'h00818663, // 15 beq  x3, x8, +12 (taken)
  32'h00100793, // 16 addi x15, x0, 1  shadow
  32'h00200793, // 17 addi x15, x0, 2  shadow
  32'h00019663, // 18 bne  x3, x0, +12 (taken)
  32'h00100813, // 19 addi x16, x0, 1  shadow
  32'h00200813, // 20 addi x16, x0, 2  shadow
  32'h00018463, // 21 beq  x3, x0, +8 (not taken)
  32'h00700893, // 22 addi x17, x0, 7
  32'h00C000EF, // 23 jal  x1, +12
  32'h00100913, // 24 addi x18, x0, 1  shadow
  32'h00200913, // 25 addi x18, x0, 2  shadow
  32'h011089B3  // 26 add  x19, x1, x17
};

localparam cpuPkg::wordT jalSelf = 32'h0000006F; // jal x0, 0 ends the program

// Expected trace of the fixed part, grouped by behavior
localparam int aluGroupEnd   = 11;
localparam int loadGroupEnd  = 14;
localparam int fixedWriteLen = 17;

localparam regWriteT fixedWrites [fixedWriteLen] = '{
  '{5'd1, 32'h12345000}, '{5'd2, 32'h12345678}, '{5'd3, 32'h00000005},
  '{5'd4, 32'h1234567D}, '{5'd5, 32'h12345678}, '{5'd6, 32'h00000000},
  '{5'd7, 32'h1234567D}, '{5'd8, 32'h00000005}, '{5'd9, 32'hFFFFFFFF},
  '{5'd10, 32'h00000001}, '{5'd11, 32'h00000000},
  '{5'd12, 32'h00000040}, '{5'd13, 32'h12345678}, '{5'd14, 32'h1234567D},
  '{5'd17, 32'h00000007}, '{5'd1, 32'h00000060}, '{5'd19, 32'h00000067}
};

localparam int fixedStoreLen = 1;

localparam storeT fixedStores [fixedStoreLen] = '{
  '{32'h00000048, 32'h12345678} // sw x2, 8(x12)
};

`endif

//--- test/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

  typedef struct packed {
    cpuPkg::regIdxT rd;
    cpuPkg::wordT   value;
  } regWriteT;

  typedef struct packed {
    cpuPkg::wordT addr;
    cpuPkg::wordT data;
  } storeT;

  `include "programTable.svh"

  localparam cpuPkg::wordT   resetPc       = 32'h0000_0000;
  localparam int             chainLen      = 16;
  localparam cpuPkg::regIdxT chainRd       = 5'd20;
  localparam int             timeoutCycles = 2000;

  logic           clk = 1'b0;
  logic           rst = 1'b1;
  cpuPkg::wordT   imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata, wbData;
  logic           dmemWe, wbValid;
  cpuPkg::regIdxT wbRd;

  cpuPkg::wordT imem [64];
  cpuPkg::wordT dmem [64];
  regWriteT     expWrites [$];
  storeT        expStores [$];
  int           writeIdx = 0;
  int           storeIdx = 0;

  cpuTop #(.resetPc(resetPc)) uut (
    .clk(clk), .rst(rst), .imemAddr_o(imemAddr), .imemData_i(imemData),
    .dmemAddr_o(dmemAddr), .dmemWdata_o(dmemWdata), .dmemWe_o(dmemWe),
    .dmemRdata_i(dmemRdata), .wbValid_o(wbValid), .wbRd_o(wbRd), .wbData_o(wbData)
  );

  always #4 clk = ~clk;

  // Combinational read memories, word addressed
  assign imemData  = imem[imemAddr[7:2]];
  assign dmemRdata = dmem[dmemAddr[7:2]];

  always @(posedge clk) begin
    if (dmemWe) begin
      dmem[dmemAddr[7:2]] <= dmemWdata;
    end
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cpuPkg::wordT encodeAddi(input cpuPkg::regIdxT rd,
                                              input cpuPkg::regIdxT rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, cpuPkg::opOpImm};
  endfunction

  function automatic string writeGroupName(input int idx);
    if (idx < aluGroupEnd) begin
      return "aluForward";
    end else if (idx < loadGroupEnd) begin
      return "loadUse";
    end else if (idx < fixedWriteLen) begin
      return "branchJump";
    end
    return "addiChain";
  endfunction

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic reportMismatch(input string name, input cpuPkg::wordT expected,
                                input cpuPkg::wordT actual);
    stopWithFailure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
  endtask

  // ==================================================
  // Trace and store monitor
  // ==================================================
  always @(negedge clk) begin
    regWriteT expW;
    storeT    expS;
    string    name;
    if (!rst && wbValid) begin
      assert (writeIdx < expWrites.size())
        else stopWithFailure($sformatf("unexpected register write to x%0d", wbRd));
      expW = expWrites[writeIdx];
      name = $sformatf("%s write %0d", writeGroupName(writeIdx), writeIdx);
      assert (wbRd == expW.rd) else reportMismatch({name, " rd"}, 32'(expW.rd), 32'(wbRd));
      assert (wbData == expW.value) else reportMismatch({name, " data"}, expW.value, wbData);
      writeIdx++;
    end
    if (!rst && dmemWe) begin
      assert (storeIdx < expStores.size())
        else stopWithFailure($sformatf("unexpected store to address %h", dmemAddr));
      expS = expStores[storeIdx];
      name = $sformatf("storeLoad store %0d", storeIdx);
      assert (dmemAddr == expS.addr) else reportMismatch({name, " addr"}, expS.addr, dmemAddr);
      assert (dmemWdata == expS.data) else reportMismatch({name, " data"}, expS.data, dmemWdata);
      storeIdx++;
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    logic [31:0]  lcgState;
    logic [11:0]  imm;
    cpuPkg::wordT runningSum;
    int           cycles;
    lcgState   = 32'hf677;
    runningSum = '0; // x20 is cleared by reset
    for (int i = 0; i < 64; i++) begin
      imem[i] = cpuPkg::nopInstr;
      dmem[i] = 32'hDA7A_0000 | (i << 2); // Tagged with the byte address
    end
    for (int i = 0; i < fixedLen; i++) begin
      imem[i] = fixedProg[i];
    end
    for (int i = 0; i < fixedWriteLen; i++) begin
      expWrites.push_back(fixedWrites[i]);
    end
    for (int i = 0; i < fixedStoreLen; i++) begin
      expStores.push_back(fixedStores[i]);
    end

    // ADDI chain, each step adds its sign-extended immediate
    for (int i = 0; i < chainLen; i++) begin
      lcgState   = lcgNext(lcgState);
      imm        = lcgState[31:20];
      imem[fixedLen + i] = encodeAddi(chainRd, chainRd, imm);
      runningSum = runningSum + {{20{imm[11]}}, imm};
      expWrites.push_back('{chainRd, runningSum});
    end
    imem[fixedLen + chainLen] = jalSelf;

    repeat (3) begin
      @(posedge clk);
      #1;
      assert (wbValid === 1'b0 && dmemWe === 1'b0)
        else stopWithFailure("trace or store strobe active during reset");
    end
    rst = 1'b0;
    @(negedge clk);
    assert (imemAddr === resetPc) else reportMismatch("resetPc", resetPc, imemAddr);

    cycles = 0;
    while ((writeIdx < expWrites.size() || storeIdx < expStores.size()) &&
           cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    repeat (8) @(posedge clk); // Let the monitor catch any stray write

    if (writeIdx == expWrites.size() && storeIdx == expStores.size()) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stopWithFailure($sformatf("timeout with %0d of %0d writes and %0d of %0d stores seen",
                                writeIdx, expWrites.size(), storeIdx, expStores.size()));
    end
  end

endmodule

//--- design/cpuTop.sv
`timescale 1ns/10ps

module cpuTop #(
  parameter cpuPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic           clk,
  input  logic           rst,
  output cpuPkg::wordT   imemAddr_o,
  input  cpuPkg::wordT   imemData_i,
  output cpuPkg::wordT   dmemAddr_o,
  output cpuPkg::wordT   dmemWdata_o,
  output logic           dmemWe_o,
  input  cpuPkg::wordT   dmemRdata_i,
  output logic           wbValid_o,
  output cpuPkg::regIdxT wbRd_o,
  output cpuPkg::wordT   wbData_o
);

  localparam cpuPkg::ifIdT ifIdBubble = '{pc: '0, instr: cpuPkg::nopInstr};

  cpuPkg::wordT   pc;
  cpuPkg::ifIdT   ifIdD, ifIdQ;
  cpuPkg::idExT   idExD, idExQ;
  cpuPkg::exMemT  exMemD, exMemQ;
  cpuPkg::memWbT  memWbD, memWbQ;
  cpuPkg::ctrlT   idCtrl;
  cpuPkg::regIdxT idRs1, idRs2, idRd;
  cpuPkg::wordT   idImm, rs1Data, rs2Data;
  cpuPkg::fwdSelE fwdA, fwdB;
  cpuPkg::wordT   aluResult, storeData, redirectPc, memFwd, wbData;
  logic           redirect, stall, flush;

  // ==================================================
  // Fetch and decode
  // ==================================================
  fetchUnit #(.resetPc(resetPc)) fetch (
    .clk(clk), .rst(rst), .stall_i(stall), .redirect_i(redirect),
    .redirectPc_i(redirectPc), .pc_o(pc)
  );

  assign imemAddr_o = pc;
  assign ifIdD      = '{pc: pc, instr: imemData_i};

  pipeReg #(.stageT(cpuPkg::ifIdT), .bubble(ifIdBubble)) ifIdReg (
    .clk(clk), .rst(rst), .stall_i(stall), .flush_i(flush), .d_i(ifIdD), .q_o(ifIdQ)
  );

  controlDecoder decoder (
    .instr_i(ifIdQ.instr), .ctrl_o(idCtrl), .rs1_o(idRs1), .rs2_o(idRs2),
    .rd_o(idRd), .imm_o(idImm)
  );

  regFile rf (
    .clk(clk), .rst(rst), .rs1_i(idRs1), .rs2_i(idRs2), .rd_i(memWbQ.rd),
    .we_i(memWbQ.regWrite), .wdata_i(wbData), .rs1Data_o(rs1Data), .rs2Data_o(rs2Data)
  );

  assign idExD = '{ctrl: idCtrl, pc: ifIdQ.pc, rs1Data: rs1Data, rs2Data: rs2Data,
                   imm: idImm, rs1: idRs1, rs2: idRs2, rd: idRd};

  // Load-use stall turns into a bubble here
  pipeReg #(.stageT(cpuPkg::idExT), .bubble('0)) idExReg (
    .clk(clk), .rst(rst), .stall_i(1'b0), .flush_i(flush || stall), .d_i(idExD), .q_o(idExQ)
  );

  // ==================================================
  // Execute and memory
  // ==================================================
  executeUnit execute (
    .idEx_i(idExQ), .fwdA_i(fwdA), .fwdB_i(fwdB), .memFwd_i(memFwd), .wbFwd_i(wbData),
    .aluResult_o(aluResult), .storeData_o(storeData),
    .redirect_o(redirect), .redirectPc_o(redirectPc)
  );

  hazardUnit hazard (
    .clk(clk), .rst(rst), .idRs1_i(idRs1), .idRs2_i(idRs2), .idEx_i(idExQ),
    .exMem_i(exMemQ), .memWb_i(memWbQ), .redirect_i(redirect),
    .fwdA_o(fwdA), .fwdB_o(fwdB), .stall_o(stall), .flush_o(flush)
  );

  assign exMemD = '{ctrl: idExQ.ctrl, pc: idExQ.pc, aluResult: aluResult,
                    storeData: storeData, rd: idExQ.rd};

  pipeReg #(.stageT(cpuPkg::exMemT), .bubble('0)) exMemReg (
    .clk(clk), .rst(rst), .stall_i(1'b0), .flush_i(1'b0), .d_i(exMemD), .q_o(exMemQ)
  );

  assign dmemAddr_o  = exMemQ.aluResult;
  assign dmemWdata_o = exMemQ.storeData;
  assign dmemWe_o    = exMemQ.ctrl.memWrite; // One strobe per store
  assign memFwd      = (exMemQ.ctrl.wbSel == cpuPkg::wbPcPlus4) ?
                       exMemQ.pc + 32'd4 : exMemQ.aluResult;

  assign memWbD = '{regWrite: exMemQ.ctrl.regWrite, wbSel: exMemQ.ctrl.wbSel,
                    pc: exMemQ.pc, aluResult: exMemQ.aluResult,
                    memData: dmemRdata_i, rd: exMemQ.rd};

  pipeReg #(.stageT(cpuPkg::memWbT), .bubble('0)) memWbReg (
    .clk(clk), .rst(rst), .stall_i(1'b0), .flush_i(1'b0), .d_i(memWbD), .q_o(memWbQ)
  );

  // ==================================================
  // Writeback and trace
  // ==================================================
  always_comb begin
    case (memWbQ.wbSel)
      cpuPkg::wbMem:     wbData = memWbQ.memData;
      cpuPkg::wbPcPlus4: wbData = memWbQ.pc + 32'd4;
      default:           wbData = memWbQ.aluResult;
    endcase
  end

  assign wbValid_o = memWbQ.regWrite && memWbQ.rd != '0;
  assign wbRd_o    = memWbQ.rd;
  assign wbData_o  = wbData;

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
  input  logic           clk,
  input  logic           rst,
  input  cpuPkg::regIdxT idRs1_i,
  input  cpuPkg::regIdxT idRs2_i,
  input  cpuPkg::idExT   idEx_i,
  input  cpuPkg::exMemT  exMem_i,
  input  cpuPkg::memWbT  memWb_i,
  input  logic           redirect_i,
  output cpuPkg::fwdSelE fwdA_o,
  output cpuPkg::fwdSelE fwdB_o,
  output logic           stall_o,
  output logic           flush_o
);

  logic loadUse;

  // Youngest producer wins
  function automatic cpuPkg::fwdSelE pickFwd(
    input cpuPkg::regIdxT src,
    input cpuPkg::exMemT  exMem,
    input cpuPkg::memWbT  memWb
  );
    if (src != '0 && exMem.ctrl.regWrite && exMem.rd == src) begin
      return cpuPkg::fwdFromMem;
    end else if (src != '0 && memWb.regWrite && memWb.rd == src) begin
      return cpuPkg::fwdFromWb;
    end
    return cpuPkg::fwdNone;
  endfunction

  assign fwdA_o = pickFwd(idEx_i.rs1, exMem_i, memWb_i);
  assign fwdB_o = pickFwd(idEx_i.rs2, exMem_i, memWb_i);

  // ==================================================
  // Load-use stall and flush
  // ==================================================
  assign loadUse = idEx_i.ctrl.memRead && idEx_i.rd != '0 &&
                   (idEx_i.rd == idRs1_i || idEx_i.rd == idRs2_i);

  assign flush_o = redirect_i;
  assign stall_o = loadUse && !redirect_i; // Flushed load-use pair needs no stall

  // The bubble behind a stalled load ends the stall after one cycle
  stallOneCycle: assert property (
    @(posedge clk) disable iff (rst) stall_o |=> !stall_o
  );

endmodule

//--- design/executeUnit.sv
`timescale 1ns/10ps

module executeUnit (
  input  cpuPkg::idExT   idEx_i,
  input  cpuPkg::fwdSelE fwdA_i,
  input  cpuPkg::fwdSelE fwdB_i,
  input  cpuPkg::wordT   memFwd_i,
  input  cpuPkg::wordT   wbFwd_i,
  output cpuPkg::wordT   aluResult_o,
  output cpuPkg::wordT   storeData_o,
  output logic           redirect_o,
  output cpuPkg::wordT   redirectPc_o
);

  cpuPkg::wordT rs1Val;
  cpuPkg::wordT rs2Val;
  cpuPkg::wordT opA;
  cpuPkg::wordT opB;
  logic         equal;
  logic         taken;

  // ==================================================
  // Operand forwarding
  // ==================================================
  always_comb begin
    case (fwdA_i)
      cpuPkg::fwdFromMem: rs1Val = memFwd_i;
      cpuPkg::fwdFromWb:  rs1Val = wbFwd_i;
      default:            rs1Val = idEx_i.rs1Data;
    endcase
    case (fwdB_i)
      cpuPkg::fwdFromMem: rs2Val = memFwd_i;
      cpuPkg::fwdFromWb:  rs2Val = wbFwd_i;
      default:            rs2Val = idEx_i.rs2Data;
    endcase
  end

  assign opA = idEx_i.ctrl.aSrcPc ? idEx_i.pc : rs1Val;
  assign opB = idEx_i.ctrl.bSrcImm ? idEx_i.imm : rs2Val;

  // ==================================================
  // ALU
  // ==================================================
  always_comb begin
    case (idEx_i.ctrl.aluOp)
      cpuPkg::aluSub:   aluResult_o = opA - opB;
      cpuPkg::aluAnd:   aluResult_o = opA & opB;
      cpuPkg::aluOr:    aluResult_o = opA | opB;
      cpuPkg::aluXor:   aluResult_o = opA ^ opB;
      cpuPkg::aluSlt:   aluResult_o = {31'b0, $signed(opA) < $signed(opB)};
      cpuPkg::aluPassB: aluResult_o = opB;
      default:          aluResult_o = opA + opB;
    endcase
  end

  assign storeData_o = rs2Val; // SW data after forwarding

  // Branch compare and target
  assign equal        = (rs1Val == rs2Val);
  assign taken        = idEx_i.ctrl.branch && (idEx_i.ctrl.branchNe ? !equal : equal);
  assign redirect_o   = taken || idEx_i.ctrl.jump;
  assign redirectPc_o = idEx_i.pc + idEx_i.imm;

endmodule

//--- design/regFile.sv
`timescale 1ns/10ps

module regFile (
  input  logic           clk,
  input  logic           rst,
  input  cpuPkg::regIdxT rs1_i,
  input  cpuPkg::regIdxT rs2_i,
  input  cpuPkg::regIdxT rd_i,
  input  logic           we_i,
  input  cpuPkg::wordT   wdata_i,
  output cpuPkg::wordT   rs1Data_o,
  output cpuPkg::wordT   rs2Data_o
);

  cpuPkg::wordT regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // Same-cycle writeback is visible to decode
  always_comb begin
    if (rs1_i == '0) begin
      rs1Data_o = '0;
    end else if (we_i && rd_i == rs1_i) begin
      rs1Data_o = wdata_i;
    end else begin
      rs1Data_o = regs[rs1_i];
    end
    if (rs2_i == '0) begin
      rs2Data_o = '0;
    end else if (we_i && rd_i == rs2_i) begin
      rs2Data_o = wdata_i;
    end else begin
      rs2Data_o = regs[rs2_i];
    end
  end

endmodule

//--- design/controlDecoder.sv
`timescale 1ns/10ps

module controlDecoder (
  input  cpuPkg::wordT   instr_i,
  output cpuPkg::ctrlT   ctrl_o,
  output cpuPkg::regIdxT rs1_o,
  output cpuPkg::regIdxT rs2_o,
  output cpuPkg::regIdxT rd_o,
  output cpuPkg::wordT   imm_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       useRs1;
  logic       useRs2;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // ==================================================
  // Control
  // ==================================================
  always_comb begin
    ctrl_o = '0; // Unknown opcodes retire as a bubble
    useRs1 = 1'b0;
    useRs2 = 1'b0;
    imm_o  = '0;
    case (opcode)
      cpuPkg::opLui: begin
        ctrl_o.regWrite = 1'b1;
        ctrl_o.bSrcImm  = 1'b1;
        ctrl_o.aluOp    = cpuPkg::aluPassB;
        imm_o           = {instr_i[31:12], 12'b0};
      end
      cpuPkg::opOpImm: begin
        if (funct3 == 3'b000) begin // ADDI only
          ctrl_o.regWrite = 1'b1;
          ctrl_o.bSrcImm  = 1'b1;
          useRs1          = 1'b1;
        end
        imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      end
      cpuPkg::opOp: begin
        ctrl_o.regWrite = 1'b1;
        useRs1          = 1'b1;
        useRs2          = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.aluOp = (funct7 == 7'b0100000) ? cpuPkg::aluSub : cpuPkg::aluAdd;
          3'b111:  ctrl_o.aluOp = cpuPkg::aluAnd;
          3'b110:  ctrl_o.aluOp = cpuPkg::aluOr;
          3'b100:  ctrl_o.aluOp = cpuPkg::aluXor;
          3'b010:  ctrl_o.aluOp = cpuPkg::aluSlt;
          default: ctrl_o.regWrite = 1'b0;
        endcase
      end
      cpuPkg::opLoad: begin
        if (funct3 == 3'b010) begin // Word access only
          ctrl_o.regWrite = 1'b1;
          ctrl_o.memRead  = 1'b1;
          ctrl_o.bSrcImm  = 1'b1;
          ctrl_o.wbSel    = cpuPkg::wbMem;
          useRs1          = 1'b1;
        end
        imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      end
      cpuPkg::opStore: begin
        if (funct3 == 3'b010) begin
          ctrl_o.memWrite = 1'b1;
          ctrl_o.bSrcImm  = 1'b1;
          useRs1          = 1'b1;
          useRs2          = 1'b1;
        end
        imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      end
      cpuPkg::opBranch: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          ctrl_o.branch   = 1'b1;
          ctrl_o.branchNe = funct3[0];
          useRs1          = 1'b1;
          useRs2          = 1'b1;
        end
        imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                 instr_i[30:25], instr_i[11:8], 1'b0};
      end
      cpuPkg::opJal: begin
        ctrl_o.regWrite = 1'b1;
        ctrl_o.jump     = 1'b1;
        ctrl_o.aSrcPc   = 1'b1; // ALU sees pc + imm
        ctrl_o.bSrcImm  = 1'b1;
        ctrl_o.wbSel    = cpuPkg::wbPcPlus4;
        imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                 instr_i[20], instr_i[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  // Unused source fields read as x0 so they never stall or forward
  assign rs1_o = useRs1 ? instr_i[19:15] : '0;
  assign rs2_o = useRs2 ? instr_i[24:20] : '0;
  assign rd_o  = instr_i[11:7];

endmodule

//--- design/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit #(
  parameter cpuPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         stall_i,
  input  logic         redirect_i,
  input  cpuPkg::wordT redirectPc_i,
  output cpuPkg::wordT pc_o
);

  cpuPkg::wordT pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= resetPc;
    end else if (redirect_i) begin
      pc <= redirectPc_i; // Taken branch or JAL wins over a stall
    end else if (!stall_i) begin
      pc <= pc + 32'd4;
    end
  end

  assign pc_o = pc;

  // Branch and jump targets from execute keep fetch on word boundaries
  pcAligned: assert property (
    @(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00
  );

endmodule

//--- design/pipeReg.sv
`timescale 1ns/10ps

module pipeReg #(
  parameter type  stageT = logic [0:0],
  parameter stageT bubble = stageT'(0)
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  stall_i,
  input  logic  flush_i,
  input  stageT d_i,
  output stageT q_o
);

  stageT q;

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      q <= bubble;
    end else if (!stall_i) begin
      q <= d_i;
    end
    // Stall keeps the current stage contents
  end

  assign q_o = q;

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

  // ==================================================
  // Base types
  // ==================================================
  typedef logic [31:0] wordT;   // Data, address or instruction word
  typedef logic [4:0]  regIdxT; // Register index

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB // LUI
  } aluOpE;

  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbPcPlus4
  } wbSelE;

  typedef enum logic [1:0] {
    fwdNone,
    fwdFromMem,
    fwdFromWb
  } fwdSelE;

  // ==================================================
  // Control and stage structs
  // ==================================================
  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  branchNe; // BNE when set, BEQ otherwise
    logic  jump;
    logic  aSrcPc;
    logic  bSrcImm;
    aluOpE aluOp;
    wbSelE wbSel;
  } ctrlT;

  typedef struct packed {
    wordT pc;
    wordT instr;
  } ifIdT;

  typedef struct packed {
    ctrlT   ctrl;
    wordT   pc;
    wordT   rs1Data;
    wordT   rs2Data;
    wordT   imm;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT rd;
  } idExT;

  typedef struct packed {
    ctrlT   ctrl;
    wordT   pc;
    wordT   aluResult;
    wordT   storeData;
    regIdxT rd;
  } exMemT;

  typedef struct packed {
    logic   regWrite;
    wbSelE  wbSel;
    wordT   pc;
    wordT   aluResult;
    wordT   memData;
    regIdxT rd;
  } memWbT;

  // ==================================================
  // Encodings
  // ==================================================
  localparam wordT nopInstr = 32'h0000_0013; // ADDI x0,x0,0

  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

endpackage
